// File: hdl/fetch_pkg.sv
// Fetch package with the shared widths, enums and packet structs of the fetch path
`default_nettype none

package fetch_pkg;

    // Data path and canonical virtual address widths
    localparam int unsigned XLEN           = 64;
    localparam int unsigned VIRT_ADDR_SIZE = 39;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     inst_t;

    // Next-PC selection from the control unit
    typedef enum logic [1:0] {
        NEXT_PC_SEL_KEEP_PC,
        NEXT_PC_SEL_BP_OR_PC_4,
        NEXT_PC_SEL_JUMP
    } next_pc_sel_t;

    // Exception causes raised by fetch as numbered in mcause
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1
    } exc_cause_t;

    typedef enum logic {
        PRED_NOT_TAKEN,
        PRED_TAKEN
    } pred_t;

    typedef struct packed {
        logic       valid;
        exc_cause_t cause;
        addr_t      origin;
    } exception_t;

    // Prediction carried down the pipe to execute
    typedef struct packed {
        logic  is_branch;
        pred_t decision;
        addr_t pred_addr;
    } bpred_t;

    // Training event from execute
    typedef struct packed {
        logic  is_branch_exe;
        addr_t pc_execution;
        logic  branch_taken_result_exe;
        addr_t branch_addr_result_exe;
    } exe_if_branch_pred_t;

    typedef struct packed {
        logic  valid;
        addr_t vaddr;
        logic  invalidate_icache;
        logic  invalidate_buffer;
    } req_cpu_icache_t;

    typedef struct packed {
        logic  valid;
        inst_t data;
    } resp_icache_cpu_t;

    typedef struct packed {
        logic       valid;
        addr_t      pc_inst;
        exception_t ex;
        bpred_t     bpred;
    } if_1_if_2_stage_t;

    // Packet handed to decode
    typedef struct packed {
        logic       valid;
        addr_t      pc_inst;
        inst_t      inst;
        exception_t ex;
        bpred_t     bpred;
    } fetch_out_t;

endpackage

`default_nettype wire

// File: hdl/branch_predictor.sv
// Branch predictor with a direct-mapped target buffer and 2-bit saturating counters
`default_nettype none

module branch_predictor #(
    parameter int unsigned BpEntries = 16
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  fetch_pkg::addr_t              pc_fetch_i,
    input  fetch_pkg::exe_if_branch_pred_t exe_i,
    output logic                          is_branch_o,
    output logic                          taken_o,
    output fetch_pkg::addr_t              pred_addr_o
);
    import fetch_pkg::*;

    localparam int unsigned IdxW = $clog2(BpEntries);
    localparam int unsigned TagW = XLEN - IdxW - 2;

    typedef logic [IdxW-1:0] idx_t;
    typedef logic [TagW-1:0] tag_t;
    typedef logic [1:0]      ctr_t;

    // Target buffer entries
    logic [BpEntries-1:0] valid_q;
    tag_t                 tag_q    [BpEntries];
    addr_t                target_q [BpEntries];
    ctr_t                 ctr_q    [BpEntries];

    idx_t rd_idx;
    tag_t rd_tag;
    idx_t upd_idx;
    tag_t upd_tag;
    logic upd_hit;
    ctr_t upd_ctr;
    ctr_t ctr_next;

    // Lookup at the fetch PC
    assign rd_idx      = pc_fetch_i[IdxW+1:2];
    assign rd_tag      = pc_fetch_i[XLEN-1:IdxW+2];
    assign is_branch_o = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign taken_o     = ctr_q[rd_idx][1];
    assign pred_addr_o = target_q[rd_idx];

    // Training index and counter step
    assign upd_idx = exe_i.pc_execution[IdxW+1:2];
    assign upd_tag = exe_i.pc_execution[XLEN-1:IdxW+2];
    assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);
    assign upd_ctr = ctr_q[upd_idx];

    always_comb begin
        if (!upd_hit) begin
            // Fresh entry starts weakly biased toward the outcome
            ctr_next = exe_i.branch_taken_result_exe ? 2'd2 : 2'd1;
        end else if (exe_i.branch_taken_result_exe) begin
            ctr_next = (upd_ctr == 2'd3) ? 2'd3 : upd_ctr + 2'd1;
        end else begin
            ctr_next = (upd_ctr == 2'd0) ? 2'd0 : upd_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (exe_i.is_branch_exe) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exe_i.is_branch_exe) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= exe_i.branch_addr_result_exe;
            ctr_q[upd_idx]    <= ctr_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/if_stage_1.sv
// Fetch stage 1 with the PC register, next-PC selection, fault checks and cache request
`default_nettype none

module if_stage_1 #(
    parameter fetch_pkg::addr_t MemBase = 64'h0000_0000_8000_0000,
    parameter fetch_pkg::addr_t MemSize = 64'h0000_0000_0001_0000
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  fetch_pkg::addr_t           reset_addr_i,
    input  logic                       stall_i,
    input  fetch_pkg::next_pc_sel_t    next_pc_sel_i,
    input  fetch_pkg::addr_t           pc_jump_i,
    input  logic                       en_translation_i,
    input  logic                       invalidate_icache_i,
    input  logic                       invalidate_buffer_i,
    input  logic                       bp_is_branch_i,
    input  logic                       bp_taken_i,
    input  fetch_pkg::addr_t           bp_addr_i,
    output fetch_pkg::addr_t           pc_o,
    output fetch_pkg::req_cpu_icache_t  req_cpu_icache_o,
    output fetch_pkg::if_1_if_2_stage_t fetch_o
);
    import fetch_pkg::*;

    localparam addr_t       MemEnd = MemBase + MemSize;
    localparam int unsigned HiW    = XLEN - VIRT_ADDR_SIZE + 1;

    addr_t          pc_q;
    addr_t          next_pc;
    logic           bp_hit_taken;
    logic [HiW-1:0] pc_hi;
    logic           canonical;
    logic           in_mem;
    logic           ex_misaligned;
    logic           ex_fault;

    assign bp_hit_taken = bp_is_branch_i && bp_taken_i;

    always_comb begin
        case (next_pc_sel_i)
            NEXT_PC_SEL_KEEP_PC:    next_pc = pc_q;
            NEXT_PC_SEL_BP_OR_PC_4: next_pc = bp_hit_taken ? bp_addr_i : pc_q + 64'd4;
            NEXT_PC_SEL_JUMP:       next_pc = pc_jump_i;
            default:                next_pc = pc_q;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= reset_addr_i;
        end else begin
            pc_q <= next_pc;
        end
    end

    // Upper bits must be a sign extension of bit VIRT_ADDR_SIZE-1
    assign pc_hi     = pc_q[XLEN-1:VIRT_ADDR_SIZE-1];
    assign canonical = (&pc_hi) || !(|pc_hi);

    // Without translation only the memory region is mapped
    assign in_mem = (pc_q >= MemBase) && (pc_q < MemEnd);

    assign ex_fault      = en_translation_i ? !canonical : !in_mem;
    assign ex_misaligned = |pc_q[1:0];

    always_comb begin
        req_cpu_icache_o.valid             = !ex_misaligned && !ex_fault && !stall_i;
        req_cpu_icache_o.vaddr             = pc_q;
        req_cpu_icache_o.invalidate_icache = invalidate_icache_i;
        req_cpu_icache_o.invalidate_buffer = invalidate_buffer_i;
    end

    always_comb begin
        fetch_o.valid     = !stall_i;
        fetch_o.pc_inst   = pc_q;
        fetch_o.ex.origin = pc_q;
        // Misalignment wins over an access fault
        if (ex_misaligned) begin
            fetch_o.ex.valid = 1'b1;
            fetch_o.ex.cause = INSTR_ADDR_MISALIGNED;
        end else if (ex_fault) begin
            fetch_o.ex.valid = 1'b1;
            fetch_o.ex.cause = INSTR_ACCESS_FAULT;
        end else begin
            fetch_o.ex.valid = 1'b0;
            fetch_o.ex.cause = INSTR_ADDR_MISALIGNED;
        end
        fetch_o.bpred.is_branch = bp_is_branch_i;
        fetch_o.bpred.decision  = bp_hit_taken ? PRED_TAKEN : PRED_NOT_TAKEN;
        fetch_o.bpred.pred_addr = bp_addr_i;
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: hdl/if_stage_2.sv
// Fetch stage 2 joining the registered stage-1 packet with the cache response
`default_nettype none

module if_stage_2 (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  fetch_pkg::if_1_if_2_stage_t stage_i,
    input  fetch_pkg::resp_icache_cpu_t resp_icache_i,
    output fetch_pkg::fetch_out_t       fetch_o
);
    import fetch_pkg::*;

    logic       valid_q;
    addr_t      pc_q;
    exception_t ex_q;
    bpred_t     bpred_q;

    // Registered packet valid
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q    <= stage_i.pc_inst;
        ex_q    <= stage_i.ex;
        bpred_q <= stage_i.bpred;
    end

    // An exception goes to decode without waiting on the cache
    always_comb begin
        fetch_o.valid   = valid_q && (ex_q.valid || resp_icache_i.valid);
        fetch_o.pc_inst = pc_q;
        fetch_o.inst    = ex_q.valid ? '0 : resp_icache_i.data;
        fetch_o.ex      = ex_q;
        fetch_o.bpred   = bpred_q;
    end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
// Fetch unit top level tying both fetch stages to the branch predictor
`default_nettype none

module fetch_unit #(
    parameter int unsigned      BpEntries = 16,
    parameter fetch_pkg::addr_t MemBase   = 64'h0000_0000_8000_0000,
    parameter fetch_pkg::addr_t MemSize   = 64'h0000_0000_0001_0000
) (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  fetch_pkg::addr_t              reset_addr_i,
    input  logic                          stall_i,
    input  fetch_pkg::next_pc_sel_t       next_pc_sel_i,
    input  fetch_pkg::addr_t              pc_jump_i,
    input  logic                          en_translation_i,
    input  logic                          invalidate_icache_i,
    input  logic                          invalidate_buffer_i,
    input  fetch_pkg::exe_if_branch_pred_t exe_if_branch_pred_i,
    input  fetch_pkg::resp_icache_cpu_t   resp_icache_i,
    output fetch_pkg::req_cpu_icache_t    req_cpu_icache_o,
    output fetch_pkg::fetch_out_t         fetch_o
);
    import fetch_pkg::*;

    addr_t            pc;
    logic             bp_is_branch;
    logic             bp_taken;
    addr_t            bp_addr;
    if_1_if_2_stage_t stage_1_2;

    if_stage_1 #(
        .MemBase (MemBase),
        .MemSize (MemSize)
    ) if_stage_1_inst (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .reset_addr_i        (reset_addr_i),
        .stall_i             (stall_i),
        .next_pc_sel_i       (next_pc_sel_i),
        .pc_jump_i           (pc_jump_i),
        .en_translation_i    (en_translation_i),
        .invalidate_icache_i (invalidate_icache_i),
        .invalidate_buffer_i (invalidate_buffer_i),
        .bp_is_branch_i      (bp_is_branch),
        .bp_taken_i          (bp_taken),
        .bp_addr_i           (bp_addr),
        .pc_o                (pc),
        .req_cpu_icache_o    (req_cpu_icache_o),
        .fetch_o             (stage_1_2)
    );

    // Lookup runs on the stage-1 PC in the same cycle
    branch_predictor #(
        .BpEntries (BpEntries)
    ) branch_predictor_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pc_fetch_i  (pc),
        .exe_i       (exe_if_branch_pred_i),
        .is_branch_o (bp_is_branch),
        .taken_o     (bp_taken),
        .pred_addr_o (bp_addr)
    );

    if_stage_2 if_stage_2_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stage_i       (stage_1_2),
        .resp_icache_i (resp_icache_i),
        .fetch_o       (fetch_o)
    );

endmodule

`default_nettype wire

// File: tests/fetch_unit_tb.sv
// Testbench for the fetch unit that acts as control unit, execute stage and instruction cache
`default_nettype none

module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    localparam addr_t       ResetAddr = 64'h0000_0000_8000_0000;
    localparam int unsigned BtEntries = 16;
    localparam int unsigned BtIdxW    = $clog2(BtEntries);

    // One stimulus line with the expected results for the PC it fetches
    typedef struct packed {
        logic [191:0]        name;
        logic [1:0]          sel;
        addr_t               jump;
        logic                stall;
        logic                trans;
        exe_if_branch_pred_t exe;
        logic                exp_req;
        logic                exp_valid;
        addr_t               exp_pc;
        logic                exp_ex_valid;
        logic [3:0]          exp_cause;
        logic                exp_taken;
    } stim_line_t;

    logic                clk_i = 1'b0;
    logic                rstn_i;
    addr_t               reset_addr_i;
    logic                stall_i;
    next_pc_sel_t        next_pc_sel_i;
    addr_t               pc_jump_i;
    logic                en_translation_i;
    logic                invalidate_icache_i;
    logic                invalidate_buffer_i;
    exe_if_branch_pred_t exe_if_branch_pred_i;
    resp_icache_cpu_t    resp_icache_i = '0;
    req_cpu_icache_t     req_cpu_icache_o;
    fetch_out_t          fetch_o;

    stim_line_t  stim_q[$];
    int          line_errors[$];
    logic [31:0] salt;
    int          check_count  = 0;
    int          error_count  = 0;
    int          failed_tests = 0;
    int          cycle_count  = 0;
    int          cycle_limit  = 0;

    // Predictor table model built from the training columns
    logic [BtEntries-1:0] bt_valid = '0;
    addr_t                bt_pc     [BtEntries];
    addr_t                bt_target [BtEntries];
    logic                 exp_hit_q[$];
    addr_t                exp_tgt_q[$];

    fetch_unit fetch_unit_inst (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .reset_addr_i         (reset_addr_i),
        .stall_i              (stall_i),
        .next_pc_sel_i        (next_pc_sel_i),
        .pc_jump_i            (pc_jump_i),
        .en_translation_i     (en_translation_i),
        .invalidate_icache_i  (invalidate_icache_i),
        .invalidate_buffer_i  (invalidate_buffer_i),
        .exe_if_branch_pred_i (exe_if_branch_pred_i),
        .resp_icache_i        (resp_icache_i),
        .req_cpu_icache_o     (req_cpu_icache_o),
        .fetch_o              (fetch_o)
    );

    always #20 clk_i = ~clk_i;

    // Instruction word for an address with a per-run salt
    function automatic inst_t inst_hash(input addr_t addr);
        logic [31:0] mix;
        mix = addr[31:0] ^ addr[63:32];
        mix = mix * 32'h9e37_79b1;
        return mix ^ salt ^ {addr[15:0], addr[31:16]};
    endfunction

    // Cache model that is always ready and answers one cycle after the request
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            resp_icache_i.valid <= 1'b0;
        end else begin
            resp_icache_i.valid <= req_cpu_icache_o.valid;
        end
        resp_icache_i.data <= inst_hash(req_cpu_icache_o.vaddr);
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic load_stimulus(output bit ok);
        int           fd;
        int           cnt;
        string        text;
        stim_line_t   entry;
        logic [191:0] name;
        logic [1:0]   sel;
        logic [63:0]  jump, bpc, btgt, pc;
        logic         stall, trans, br, btk, req, val, exv, dec;
        logic [3:0]   cause;
        ok = 1'b1;
        fd = $fopen("tests/fetch_unit_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tests/fetch_unit_stim.txt");
            ok = 1'b0;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            // Skip blank lines and column notes
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            cnt = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          name, sel, jump, stall, trans, br, bpc, btk, btgt,
                          req, val, pc, exv, cause, dec);
            if (cnt != 15) begin
                $display("Malformed stimulus line: %0s", text);
                ok = 1'b0;
            end else begin
                entry.name                        = name;
                entry.sel                         = sel;
                entry.jump                        = jump;
                entry.stall                       = stall;
                entry.trans                       = trans;
                entry.exe.is_branch_exe           = br;
                entry.exe.pc_execution            = bpc;
                entry.exe.branch_taken_result_exe = btk;
                entry.exe.branch_addr_result_exe  = btgt;
                entry.exp_req                     = req;
                entry.exp_valid                   = val;
                entry.exp_pc                      = pc;
                entry.exp_ex_valid                = exv;
                entry.exp_cause                   = cause;
                entry.exp_taken                   = dec;
                stim_q.push_back(entry);
                line_errors.push_back(0);
            end
        end
        $fclose(fd);
        if (stim_q.size() == 0) begin
            $display("The stimulus file holds no test lines");
            ok = 1'b0;
        end
    endtask

    task automatic check_value(input int idx, input string field,
                               input logic [63:0] exp_val, input logic [63:0] act_val);
        check_count = check_count + 1;
        if (exp_val !== act_val) begin
            $display("[FAIL] %0s %0s: expected %h, actual %h",
                     stim_q[idx].name, field, exp_val, act_val);
            error_count      = error_count + 1;
            line_errors[idx] = line_errors[idx] + 1;
        end
    endtask

    // Table lookup for the stage-1 PC, then the training of the same cycle
    task automatic model_predictor(input int idx);
        stim_line_t line;
        int         slot;
        line = stim_q[idx];
        slot = int'(line.exp_pc[BtIdxW+1:2]);
        exp_hit_q.push_back(bt_valid[slot] && (bt_pc[slot][63:2] == line.exp_pc[63:2]));
        exp_tgt_q.push_back(bt_target[slot]);
        if (line.exe.is_branch_exe) begin
            slot            = int'(line.exe.pc_execution[BtIdxW+1:2]);
            bt_valid[slot]  = 1'b1;
            bt_pc[slot]     = line.exe.pc_execution;
            bt_target[slot] = line.exe.branch_addr_result_exe;
        end
    endtask

    // Decode packet for a line shows up one cycle after its PC
    task automatic check_fetch(input int idx);
        stim_line_t line;
        inst_t      exp_inst;
        line = stim_q[idx];
        check_value(idx, "fetch_valid", 64'(line.exp_valid), 64'(fetch_o.valid));
        if (line.exp_valid) begin
            exp_inst = line.exp_ex_valid ? '0 : inst_hash(line.exp_pc);
            check_value(idx, "pc_inst", line.exp_pc, fetch_o.pc_inst);
            check_value(idx, "inst", 64'(exp_inst), 64'(fetch_o.inst));
            check_value(idx, "ex_valid", 64'(line.exp_ex_valid), 64'(fetch_o.ex.valid));
            if (line.exp_ex_valid) begin
                check_value(idx, "ex_cause", 64'(line.exp_cause), 64'(fetch_o.ex.cause));
                check_value(idx, "ex_origin", line.exp_pc, fetch_o.ex.origin);
            end
            check_value(idx, "decision", 64'(line.exp_taken), 64'(fetch_o.bpred.decision));
            check_value(idx, "is_branch", 64'(exp_hit_q[idx]), 64'(fetch_o.bpred.is_branch));
            if (exp_hit_q[idx]) begin
                check_value(idx, "pred_addr", exp_tgt_q[idx], fetch_o.bpred.pred_addr);
            end
        end
    endtask

    task automatic report_test(input int idx);
        if (line_errors[idx] == 0) begin
            $display("test %0s: ok", stim_q[idx].name);
        end else begin
            $display("test %0s: %0d mismatches", stim_q[idx].name, line_errors[idx]);
            failed_tests = failed_tests + 1;
        end
    endtask

    task automatic run_lines();
        stim_line_t line;
        for (int k = 0; k <= stim_q.size(); k++) begin
            @(posedge clk_i);
            rstn_i <= 1'b1;
            if (k < stim_q.size()) begin
                line = stim_q[k];
                next_pc_sel_i        <= next_pc_sel_t'(line.sel);
                pc_jump_i            <= line.jump;
                stall_i              <= line.stall;
                en_translation_i     <= line.trans;
                exe_if_branch_pred_i <= line.exe;
                // Walk all four invalidate combinations
                invalidate_icache_i  <= k[0];
                invalidate_buffer_i  <= k[1];
            end else begin
                // Idle cycle to collect the last packet
                next_pc_sel_i        <= NEXT_PC_SEL_KEEP_PC;
                stall_i              <= 1'b1;
                exe_if_branch_pred_i <= '0;
                invalidate_icache_i  <= 1'b0;
                invalidate_buffer_i  <= 1'b0;
            end
            @(negedge clk_i);
            if (k < stim_q.size()) begin
                check_value(k, "req_valid", 64'(stim_q[k].exp_req),
                            64'(req_cpu_icache_o.valid));
                check_value(k, "req_vaddr", stim_q[k].exp_pc, req_cpu_icache_o.vaddr);
                check_value(k, "inv_icache", 64'(k[0]),
                            64'(req_cpu_icache_o.invalidate_icache));
                check_value(k, "inv_buffer", 64'(k[1]),
                            64'(req_cpu_icache_o.invalidate_buffer));
                model_predictor(k);
            end
            if (k > 0) begin
                check_fetch(k - 1);
                report_test(k - 1);
            end
        end
    endtask

    initial begin
        bit loaded;
        salt                 = $urandom(32'ha69e);
        rstn_i               = 1'b0;
        reset_addr_i         = ResetAddr;
        stall_i              = 1'b0;
        next_pc_sel_i        = NEXT_PC_SEL_KEEP_PC;
        pc_jump_i            = '0;
        en_translation_i     = 1'b0;
        invalidate_icache_i  = 1'b0;
        invalidate_buffer_i  = 1'b0;
        exe_if_branch_pred_i = '0;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("No usable stimulus, the run stops before reset");
            $display("Done: errors found");
            $finish;
        end else begin
            cycle_limit = stim_q.size() + 20;
            repeat (2) @(posedge clk_i);
            run_lines();
            $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                     stim_q.size(), failed_tests, check_count, error_count);
            if (error_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/fetch_unit_stim.txt
# name sel pc_jump stall en_trans exe_is_branch exe_pc exe_taken exe_target
# then expected: req_valid fetch_valid fetch_pc ex_valid ex_cause decision
seq_0    1 0                0 0 0 0        0 0         1 1 80000000         0 0 0
seq_1    1 0                0 0 0 0        0 0         1 1 80000004         0 0 0
seq_2    1 0                0 0 0 0        0 0         1 1 80000008         0 0 0
seq_3    2 80000100         0 0 0 0        0 0         1 1 8000000c         0 0 0
jump_0   1 0                0 0 0 0        0 0         1 1 80000100         0 0 0
stall_0  0 0                1 0 0 0        0 0         0 0 80000104         0 0 0
stall_1  0 0                1 0 0 0        0 0         0 0 80000104         0 0 0
resume_0 2 80000102         0 0 0 0        0 0         1 1 80000104         0 0 0
misal_0  2 1002             0 0 0 0        0 0         0 1 80000102         1 0 0
misal_1  2 1000             0 0 0 0        0 0         0 1 1002             1 0 0
fault_0  2 80010000         0 0 0 0        0 0         0 1 1000             1 1 0
fault_1  2 4000000000       0 0 0 0        0 0         0 1 80010000         1 1 0
canon_0  2 ffffffc000000000 0 1 0 0        0 0         0 1 4000000000       1 1 0
canon_1  2 1000             0 1 0 0        0 0         1 1 ffffffc000000000 0 0 0
canon_2  2 80000300         0 1 0 0        0 0         1 1 1000             0 0 0
train_0  0 0                0 0 1 80000200 1 80000400  1 1 80000300         0 0 0
train_1  2 80000200         0 0 1 80000200 1 80000400  1 1 80000300         0 0 0
pred_0   1 0                0 0 0 0        0 0         1 1 80000200         0 0 1
pred_1   2 80000200         0 0 0 0        0 0         1 1 80000400         0 0 0
ntrain_0 0 0                0 0 1 80000200 0 80000400  1 1 80000200         0 0 1
ntrain_1 0 0                0 0 1 80000200 0 80000400  1 1 80000200         0 0 1
npred_0  1 0                0 0 0 0        0 0         1 1 80000200         0 0 0
npred_1  1 0                0 0 0 0        0 0         1 1 80000204         0 0 0
seq_4    1 0                0 0 0 0        0 0         1 1 80000208         0 0 0

// File: fetch_unit.f
hdl/fetch_pkg.sv
hdl/branch_predictor.sv
hdl/if_stage_1.sv
hdl/if_stage_2.sv
hdl/fetch_unit.sv
tests/fetch_unit_tb.sv

// File: Makefile
TOP := fetch_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f fetch_unit.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" sim.log; then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
